// File: files.f
design/pcie_pkg.sv
design/video_pkg.sv
design/cmd_decoder.sv
design/pixel_fifo.sv
design/mwr_tx.sv
design/pcie_dma_ctrl.sv
tb/dma_props.sv
tb/tb_pcie_dma_ctrl.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
RUN_FLAGS  = +verilator+error+limit+10
TOP        = tb_pcie_dma_ctrl
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -q -F '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_pcie_dma_ctrl.sv
module tb_pcie_dma_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import pcie_pkg::*;
    import video_pkg::*;

    localparam int TLP_DW     = 16;
    localparam int FIFO_DEPTH = 32;
    localparam int FRAME_PIX  = 128;       // four TLPs per frame
    localparam int TLP_PIX    = TLP_DW * 2;
    localparam int FRAMES     = 9;
    localparam int SEED       = 97;

    logic        clk;
    logic        rstn;
    logic        rx_tvalid, rx_tlast;
    word_t       rx_tdata;
    bus_num_t    bus_num;
    dev_num_t    dev_num;
    logic        vs, de;
    pixel_t      pix_data;
    logic        tx_tvalid, tx_tlast, tx_tready;
    word_t       tx_tdata;
    enhance_t    enhance;

    word_t       exp_q[$];   // expected beats in order
    logic        last_q[$];
    addr_t       bufs [4];
    pixel_t      frame_pix [FRAME_PIX];
    logic [1:0]  page;       // buffer page of the next frame
    int          n_addr;     // ring writes since reset or clear
    logic [31:0] pix_state;
    logic [31:0] rdy_state;

    pcie_dma_ctrl #(.TLP_DW(TLP_DW), .FIFO_DEPTH(FIFO_DEPTH)) dut0 (.*);

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // byte order reversed inside every DW
    function automatic word_t swap_dws(input word_t w);
        word_t r;
        for (int b = 0; b < 16; b++) begin
            r[8*b +: 8] = w[8*((b & ~3) + 3 - (b & 3)) +: 8];
        end
        return r;
    endfunction

    function automatic word_t header_beat(input addr_t addr);
        logic [31:0] dw0;
        logic [31:0] dw1;
        dw0 = {3'b010, 5'b00000, 14'd0, 10'(TLP_DW)};        // MWr32 with the length in DW
        dw1 = {bus_num, dev_num, 3'b000, 8'h01, 4'hf, 4'hf};  // req id, tag, byte enables
        return {32'd0, addr, dw1, dw0};
    endfunction

    task automatic value_error(input string name, input word_t exp, input word_t act);
        $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        $display("** FAIL **");
        $fatal(1, "value mismatch");
    endtask

    task automatic plain_error(input string what);
        $display("%s at %0t ns", what, $time);
        $display("** FAIL **");
        $fatal(1, "run stopped");
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        rdy_state = next_random(rdy_state);
        tx_tready = (rdy_state[18:17] != 2'b00);  // ready about 3 cycles in 4
    end

    // beat checker sampling where the outputs have settled
    always @(negedge clk) begin
        if (rstn && tx_tvalid) begin
            assert (exp_q.size() != 0)
                else plain_error("tx_tvalid raised while no TLP was expected");
            if (tx_tready) begin
                assert (tx_tdata == exp_q[0])
                    else value_error("tx_tdata", exp_q[0], tx_tdata);
                assert (tx_tlast == last_q[0])
                    else value_error("tx_tlast", word_t'(last_q[0]), word_t'(tx_tlast));
                void'(exp_q.pop_front());
                void'(last_q.pop_front());
            end
        end
        if (dut0.u_props.prop_fail) begin
            plain_error("stream protocol property failed");
        end
    end

    initial begin
        #(2 * FRAMES * FRAME_PIX * 8 + 20000);
        plain_error("watchdog expired before the test finished");
    end

    task automatic send_cmd(input cmd_off_t off, input logic [31:0] value);
        @(posedge clk);
        #1;
        rx_tvalid = 1'b1;
        rx_tlast  = 1'b0;
        rx_tdata  = {32'd0, {20'hf0000, off}, 32'h0000_00ff, 32'h4000_0001};
        @(posedge clk);
        #1;
        rx_tlast  = 1'b1;
        rx_tdata  = {96'd0, value[7:0], value[15:8], value[23:16], value[31:24]};
        @(posedge clk);
        #1;
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
    endtask

    task automatic check_enhance(input enhance_t exp);
        @(negedge clk);
        assert (enhance == exp)
            else value_error("enhance", word_t'(exp), word_t'(enhance));
    endtask

    task automatic write_buf(input addr_t a);
        send_cmd(CMD_DMA_ADDR, a);
        bufs[n_addr % 4] = a;
        n_addr++;
    endtask

    task automatic run_frame();
        addr_t base;
        word_t d;
        int    sent;
        @(posedge clk);
        #1;
        vs = 1'b1;  // end of the previous frame
        for (int i = 0; i < FRAME_PIX; i++) begin
            pix_state    = next_random(pix_state);
            frame_pix[i] = pix_state[31:16];
        end
        if (n_addr >= 4) begin
            base = bufs[page];
            page = page + 2'd1;
            for (int t = 0; t < FRAME_PIX / TLP_PIX; t++) begin
                exp_q.push_back(header_beat(base + addr_t'(64 * t)));
                last_q.push_back(1'b0);
                for (int w = 0; w < TLP_DW / 4; w++) begin
                    for (int p = 0; p < PIX_PER_WORD; p++) begin
                        d[16*p +: 16] = frame_pix[TLP_PIX*t + PIX_PER_WORD*w + p];
                    end
                    exp_q.push_back(swap_dws(d));
                    last_q.push_back(w == TLP_DW / 4 - 1);
                end
            end
        end
        repeat (6) @(posedge clk);
        #1;
        vs = 1'b0;  // frame starts
        repeat (4) @(posedge clk);
        sent = 0;
        while (sent < FRAME_PIX) begin
            @(posedge clk);
            #1;
            pix_state = next_random(pix_state);
            de        = (pix_state[21:20] != 2'b00);
            pix_data  = de ? frame_pix[sent] : pix_state[15:0];  // junk during gaps
            if (de) begin
                sent++;
            end
        end
        @(posedge clk);
        #1;
        de = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (16) @(posedge clk);
    endtask

    initial begin
        rstn      = 1'b0;
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        rx_tdata  = '0;
        bus_num   = 8'h3a;
        dev_num   = 5'h05;
        vs        = 1'b0;
        de        = 1'b0;
        pix_data  = '0;
        tx_tready = 1'b0;
        pix_state = SEED;
        rdy_state = SEED;
        page      = 2'd0;
        n_addr    = 0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        send_cmd(CMD_DARKUP, 32'h0000_005a);
        check_enhance(enhance_t'({8'h00, 1'b0, 8'h5a, 1'b1}));
        send_cmd(CMD_LIGHTDOWN, 32'h0000_00c3);
        check_enhance(enhance_t'({8'hc3, 1'b1, 8'h5a, 1'b1}));
        send_cmd(CMD_ENHANCE_CLEAR, 32'd0);
        check_enhance(enhance_t'(0));

        // half filled ring must stay quiet
        write_buf(32'h1000_0000);
        write_buf(32'h2000_0400);
        run_frame();
        write_buf(32'h3000_0800);
        write_buf(32'h4000_0c00);
        repeat (5) run_frame();

        write_buf(32'h5000_1000);  // ring pointer left off entry 0
        send_cmd(CMD_DARKUP, 32'h0000_0011);
        check_enhance(enhance_t'({8'h00, 1'b0, 8'h11, 1'b1}));
        send_cmd(CMD_DMA_CLEAR, 32'd0);
        check_enhance(enhance_t'(0));
        n_addr = 0;
        page   = 2'd0;
        run_frame();

        write_buf(32'h8000_0000);
        write_buf(32'h8100_0000);
        write_buf(32'h8200_0000);
        write_buf(32'h8300_0000);
        repeat (2) run_frame();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: tb/dma_props.sv
module dma_props (
    input logic             clk,
    input logic             rstn,
    input logic             tx_tvalid,
    input logic             tx_tready,
    input video_pkg::word_t tx_tdata,
    input logic             tx_tlast,
    input logic             armed
);
    timeunit 1ns;
    timeprecision 100ps;

    logic hold_fail  = 1'b0;
    logic last_fail  = 1'b0;
    logic armed_fail = 1'b0;
    logic prop_fail;

    assign prop_fail = hold_fail || last_fail || armed_fail;  // watched by the testbench

    // stalled beat stays put until the host takes it
    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast))
        else begin
            hold_fail = 1'b1;
            $error("tx beat changed while stalled");
        end

    last_in_beat: assert property (@(posedge clk) disable iff (!rstn)
        tx_tlast |-> tx_tvalid)
        else begin
            last_fail = 1'b1;
            $error("tx_tlast high without tx_tvalid");
        end

    // no writes to host memory before the ring is complete
    valid_armed: assert property (@(posedge clk) disable iff (!rstn)
        tx_tvalid |-> armed)
        else begin
            armed_fail = 1'b1;
            $error("tx_tvalid high while DMA not armed");
        end

endmodule

bind pcie_dma_ctrl dma_props u_props (
    .clk       (clk),
    .rstn      (rstn),
    .tx_tvalid (tx_tvalid),
    .tx_tready (tx_tready),
    .tx_tdata  (tx_tdata),
    .tx_tlast  (tx_tlast),
    .armed     (dma_addrs.armed)
);

// File: design/pcie_dma_ctrl.sv
module pcie_dma_ctrl #(
    parameter int TLP_DW     = 16,
    parameter int FIFO_DEPTH = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                rx_tvalid,
    input  video_pkg::word_t    rx_tdata,
    input  logic                rx_tlast,
    input  pcie_pkg::bus_num_t  bus_num,
    input  pcie_pkg::dev_num_t  dev_num,
    input  logic                vs,
    input  logic                de,
    input  video_pkg::pixel_t   pix_data,
    output logic                tx_tvalid,
    output video_pkg::word_t    tx_tdata,
    output logic                tx_tlast,
    input  logic                tx_tready,
    output video_pkg::enhance_t enhance
);
    import pcie_pkg::*;
    import video_pkg::*;

    dma_addrs_t dma_addrs;
    logic       dma_clear;
    logic       frame_active;
    logic       rd_en;
    word_t      rd_data;
    level_t     level;

    cmd_decoder u_cmd (
        .clk       (clk),
        .rstn      (rstn),
        .rx_tvalid (rx_tvalid),
        .rx_tdata  (rx_tdata),
        .rx_tlast  (rx_tlast),
        .dma_addrs (dma_addrs),
        .enhance   (enhance),
        .dma_clear (dma_clear)
    );

    pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .flush    (vs || dma_clear),     // emptied during vertical blank
        .wr_en    (de && frame_active),
        .pix_data (pix_data),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .level    (level)
    );

    mwr_tx #(.TLP_DW(TLP_DW)) u_tx (
        .clk          (clk),
        .rstn         (rstn),
        .vs           (vs),
        .dma_addrs    (dma_addrs),
        .dma_clear    (dma_clear),
        .bus_num      (bus_num),
        .dev_num      (dev_num),
        .level        (level),
        .rd_data      (rd_data),
        .rd_en        (rd_en),
        .frame_active (frame_active),
        .tx_tvalid    (tx_tvalid),
        .tx_tdata     (tx_tdata),
        .tx_tlast     (tx_tlast),
        .tx_tready    (tx_tready)
    );

endmodule

// File: design/mwr_tx.sv
module mwr_tx #(
    parameter int TLP_DW = 16
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 vs,
    input  pcie_pkg::dma_addrs_t dma_addrs,
    input  logic                 dma_clear,
    input  pcie_pkg::bus_num_t   bus_num,
    input  pcie_pkg::dev_num_t   dev_num,
    input  video_pkg::level_t    level,
    input  video_pkg::word_t     rd_data,
    output logic                 rd_en,
    output logic                 frame_active,
    output logic                 tx_tvalid,
    output video_pkg::word_t     tx_tdata,
    output logic                 tx_tlast,
    input  logic                 tx_tready
);
    import pcie_pkg::*;
    import video_pkg::*;

    localparam int BEATS = TLP_DW / 4;  // 128-bit data beats per TLP
    localparam int CW    = $clog2(BEATS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_DATA
    } tx_state_t;

    tx_state_t     state;
    logic          vs_d0;
    logic          vs_d1;
    logic          vs_rise;
    logic          vs_fall;
    logic [1:0]    page;
    addr_t         cur_addr;   // address of the next TLP
    logic [CW-1:0] beat_cnt;
    req_id_t       req_id;
    word_t         hdr_word;
    word_t         data_swap;

    assign vs_rise = vs_d0 && !vs_d1;  // frame end
    assign vs_fall = !vs_d0 && vs_d1;  // frame start
    assign req_id  = {bus_num, dev_num, 3'b000};

    // 3DW MWr header, upper DW unused
    assign hdr_word = {32'd0, cur_addr, req_id, TAG_MWR, BE_ALL, BE_ALL,
                       FMT_MWR32, TYPE_MWR32, 14'd0, tlp_len_t'(TLP_DW)};

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            data_swap[32*i +: 32] = dw_swap(rd_data[32*i +: 32]);
        end
    end

    assign tx_tdata = (state == ST_DATA) ? data_swap : hdr_word;
    assign rd_en    = (state == ST_DATA) && tx_tready;  // pop on accepted data beat

    always_ff @(posedge clk) begin
        if (!rstn) begin
            vs_d0 <= 1'b0;
            vs_d1 <= 1'b0;
        end else begin
            vs_d0 <= vs;
            vs_d1 <= vs_d0;
        end
    end

    // frame state and buffer page
    always_ff @(posedge clk) begin
        if (!rstn || dma_clear) begin
            frame_active <= 1'b0;
            page         <= 2'd0;
        end else if (vs_rise) begin
            frame_active <= 1'b0;
            if (dma_addrs.armed) begin
                page <= page + 2'd1;  // pages only rotate while armed
            end
        end else if (vs_fall && dma_addrs.armed) begin
            frame_active <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (vs_rise) begin
            cur_addr <= dma_addrs.addr[page];
        end else if (state == ST_DATA && tx_tready && tx_tlast) begin
            cur_addr <= cur_addr + addr_t'(TLP_DW * 4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || dma_clear || vs_rise) begin
            state     <= ST_IDLE;
            tx_tvalid <= 1'b0;
            tx_tlast  <= 1'b0;
            beat_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_active && level >= level_t'(BEATS)) begin
                        state     <= ST_HDR;
                        tx_tvalid <= 1'b1;
                    end
                end
                ST_HDR: begin
                    if (tx_tready) begin
                        state    <= ST_DATA;
                        beat_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    if (tx_tready) begin
                        if (tx_tlast) begin
                            state     <= ST_IDLE;
                            tx_tvalid <= 1'b0;
                            tx_tlast  <= 1'b0;
                        end else begin
                            beat_cnt <= beat_cnt + 1'b1;
                            tx_tlast <= (beat_cnt == CW'(BEATS - 2));  // next beat is last
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: design/pixel_fifo.sv
module pixel_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              flush,
    input  logic              wr_en,
    input  video_pkg::pixel_t pix_data,
    input  logic              rd_en,
    output video_pkg::word_t  rd_data,
    output video_pkg::level_t level
);
    import video_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int PW = $clog2(PIX_PER_WORD);

    pixel_t [PIX_PER_WORD-2:0] pack;  // pixels waiting for the last one of the word
    logic   [PW-1:0]           pix_idx;
    logic                      last_pix;
    word_t                     mem [FIFO_DEPTH];
    logic   [AW-1:0]           wr_ptr;
    logic   [AW-1:0]           rd_ptr;
    logic                      full;
    logic                      word_wr;
    logic                      word_rd;

    assign last_pix = (pix_idx == PW'(PIX_PER_WORD - 1));
    assign full     = (level == level_t'(FIFO_DEPTH));
    assign word_wr  = wr_en && last_pix && !full;  // drop on overflow
    assign word_rd  = rd_en && (level != '0);
    assign rd_data  = mem[rd_ptr];                 // show-ahead head word

    always_ff @(posedge clk) begin
        if (wr_en && !last_pix) begin
            pack[pix_idx] <= pix_data;
        end
        if (word_wr) begin
            mem[wr_ptr] <= {pix_data, pack};  // pixel 0 ends up in the low bits
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            pix_idx <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level   <= '0;
        end else begin
            if (wr_en) begin
                pix_idx <= last_pix ? '0 : pix_idx + 1'b1;
            end
            if (word_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (word_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({word_wr, word_rd})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

endmodule

// File: design/cmd_decoder.sv
module cmd_decoder (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 rx_tvalid,
    input  video_pkg::word_t     rx_tdata,
    input  logic                 rx_tlast,
    output pcie_pkg::dma_addrs_t dma_addrs,
    output video_pkg::enhance_t  enhance,
    output logic                 dma_clear
);
    import pcie_pkg::*;

    typedef enum logic [1:0] {
        RING_0,
        RING_1,
        RING_2,
        RING_3
    } ring_t;

    logic        first_beat;  // next valid beat opens a packet
    logic        hdr_seen;    // header taken, payload beat pending
    logic        hdr_cmd;     // header is a 1-DW MWr32
    cmd_off_t    hdr_off;
    ring_t       ring_ptr;
    addr_t [3:0] ring;
    addr_t       payload;
    logic        cmd_hit;

    assign payload = dw_swap(rx_tdata[31:0]);
    assign cmd_hit = rx_tvalid && hdr_seen && hdr_cmd;

    always_comb begin
        dma_addrs.addr  = ring;
        dma_addrs.armed = (ring[0] != '0) && (ring[1] != '0) &&
                          (ring[2] != '0) && (ring[3] != '0);
    end

    // packet position
    always_ff @(posedge clk) begin
        if (!rstn) begin
            first_beat <= 1'b1;
            hdr_seen   <= 1'b0;
        end else if (rx_tvalid) begin
            first_beat <= rx_tlast;
            hdr_seen   <= first_beat && !rx_tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_tvalid && first_beat) begin
            hdr_cmd <= ({rx_tdata[31:29], rx_tdata[28:24]} == {FMT_MWR32, TYPE_MWR32}) &&
                       (rx_tdata[9:0] == tlp_len_t'(1));
            hdr_off <= rx_tdata[75:64];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ring_ptr  <= RING_0;
            ring      <= '0;
            enhance   <= '0;
            dma_clear <= 1'b0;
        end else begin
            dma_clear <= 1'b0;
            if (cmd_hit) begin
                case (hdr_off)
                    CMD_DMA_ADDR: begin
                        ring[ring_ptr] <= payload;
                        ring_ptr       <= ring_t'(ring_ptr + 2'd1);  // wraps after entry 3
                    end
                    CMD_DMA_CLEAR: begin
                        ring      <= '0;
                        ring_ptr  <= RING_0;
                        enhance   <= '0;
                        dma_clear <= 1'b1;
                    end
                    CMD_LIGHTDOWN: begin
                        enhance.lightdown_num <= payload[7:0];
                        enhance.lightdown_sw  <= 1'b1;
                    end
                    CMD_DARKUP: begin
                        enhance.darkup_num <= payload[7:0];
                        enhance.darkup_sw  <= 1'b1;
                    end
                    CMD_ENHANCE_CLEAR: enhance <= '0;
                    default: ;  // other offsets ignored
                endcase
            end
        end
    end

endmodule

// File: design/video_pkg.sv
package video_pkg;

    typedef logic [15:0]  pixel_t;
    typedef logic [127:0] word_t;   // one stream beat

    localparam int PIX_PER_WORD = 8;

    typedef logic [5:0] level_t;    // FIFO word count

    // video enhance settings, driven out to the pixel pipe
    typedef struct packed {
        logic [7:0] lightdown_num;
        logic       lightdown_sw;
        logic [7:0] darkup_num;
        logic       darkup_sw;
    } enhance_t;

endpackage

// File: design/pcie_pkg.sv
package pcie_pkg;

    typedef logic [9:0]  tlp_len_t;  // length field in DW
    typedef logic [31:0] addr_t;     // host byte address
    typedef logic [15:0] req_id_t;
    typedef logic [7:0]  bus_num_t;
    typedef logic [4:0]  dev_num_t;
    typedef logic [11:0] cmd_off_t;  // low bits of the BAR address

    // 3DW memory write, fmt/type byte 0x40
    localparam logic [2:0] FMT_MWR32  = 3'b010;
    localparam logic [4:0] TYPE_MWR32 = 5'b00000;

    // command register offsets
    localparam cmd_off_t CMD_DMA_ADDR      = 12'h110;
    localparam cmd_off_t CMD_DMA_CLEAR     = 12'h130;
    localparam cmd_off_t CMD_LIGHTDOWN     = 12'h140;
    localparam cmd_off_t CMD_DARKUP        = 12'h150;
    localparam cmd_off_t CMD_ENHANCE_CLEAR = 12'h160;

    localparam logic [7:0] TAG_MWR = 8'h01;
    localparam logic [3:0] BE_ALL  = 4'hf;

    // frame buffer ring as seen by the writer
    typedef struct packed {
        addr_t [3:0] addr;   // entry 0 in the low bits
        logic        armed;  // all four entries non-zero
    } dma_addrs_t;

    // byte order reversal within one DW
    function automatic logic [31:0] dw_swap(input logic [31:0] dw);
        logic [31:0] res;
        res = {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
        return res;
    endfunction

endpackage
